/* PipeCore.f */
src/CorePkg.sv
src/DecodeBus.sv
src/InstrFetch.sv
src/DecodeStage.sv
src/ExecuteStage.sv
src/RegisterFile.sv
src/PipeCore.sv
verif/PipeCore_checker.sv
verif/PipeCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the core and testbench with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module PipeCoreTb -f PipeCore.f \
    && ./obj_dir/VPipeCoreTb | tee /dev/stderr | grep -qF "Done: no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verif/PipeCoreTb.sv */
//--------------------
// Testbench for the pipeline core
// Runs two programs from a table: one of no-ops and register 0 writes,
// one built from random constants. A reference model fills the expected
// registers, and the check port is walked after each program
//--------------------

module PipeCoreTb;

    localparam int AddrWidth   = 16;
    localparam int ClockPeriod = 100;
    localparam int ResetCycles = 2;
    localparam int ProgDepth   = 64;
    localparam int DrainCycles = 4;
    // Reset, program, drain and the register walk for one program
    localparam int PhaseCycles   = ResetCycles + ProgDepth + DrainCycles + 2 * 32 + 2;
    localparam int TimeoutCycles = 2 * PhaseCycles + 40;

    logic                 Clock;
    logic                 nReset;
    CorePkg::WordT        InstrMem;
    CorePkg::RegAddrT     RegAddr;
    logic [AddrWidth-1:0] InstrAddr;
    CorePkg::WordT        RegData;

    CorePkg::WordT progMem [ProgDepth];
    CorePkg::WordT expRegs [32];
    int            progLen;
    int            seed;

    PipeCore #(
        .AddrWidth (AddrWidth)
    ) u_PipeCore (
        .Clock     (Clock),
        .nReset    (nReset),
        .InstrMem  (InstrMem),
        .RegAddr   (RegAddr),
        .InstrAddr (InstrAddr),
        .RegData   (RegData)
    );

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    // Encoders --------------------

    function automatic CorePkg::WordT rType(input CorePkg::FuncE fn,
                                            input CorePkg::RegAddrT rd,
                                            input CorePkg::RegAddrT rs,
                                            input CorePkg::RegAddrT rt,
                                            input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, fn};
    endfunction

    function automatic CorePkg::WordT iType(input logic [5:0] op,
                                            input CorePkg::RegAddrT rt,
                                            input CorePkg::RegAddrT rs,
                                            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addInstr(input CorePkg::WordT w);
        progMem[progLen[5:0]] = w;
        progLen++;
    endtask

    // Instruction memory, zero past the end of the program
    function automatic CorePkg::WordT fetchWord();
        if (int'(InstrAddr[AddrWidth-1:2]) < progLen) begin
            return progMem[InstrAddr[7:2]];
        end
        return '0;
    endfunction

    initial begin
        InstrMem = '0;
        forever begin
            @(negedge Clock);
            InstrMem = fetchWord();
        end
    end

    // Reference model --------------------

    function automatic void modelStep(input CorePkg::WordT w);
        CorePkg::WordT    a;
        CorePkg::WordT    b;
        CorePkg::WordT    res;
        CorePkg::RegAddrT dest;
        logic             writes;
        a      = expRegs[w[25:21]];
        b      = expRegs[w[20:16]];
        dest   = w[15:11];
        writes = 1'b1;
        res    = '0;
        case (w[31:26])
            6'h00: begin
                case (w[5:0])
                    6'h00:   res = b << w[10:6];
                    6'h02:   res = b >> w[10:6];
                    6'h21:   res = a + b;
                    6'h23:   res = a - b;
                    6'h24:   res = a & b;
                    6'h25:   res = a | b;
                    6'h26:   res = a ^ b;
                    6'h27:   res = ~(a | b);
                    6'h2A:   res = {31'b0, $signed(a) < $signed(b)};
                    default: writes = 1'b0;
                endcase
            end
            6'h09: begin
                dest = w[20:16];
                res  = a + {{16{w[15]}}, w[15:0]};
            end
            6'h0D: begin
                dest = w[20:16];
                res  = a | {16'h0000, w[15:0]};
            end
            6'h0F: begin
                dest = w[20:16];
                res  = {w[15:0], 16'h0000};
            end
            default: writes = 1'b0;
        endcase
        if (writes && dest != 5'd0) begin
            expRegs[dest] = res;
        end
    endfunction

    // Programs --------------------

    task automatic buildZero();
        progLen = 0;
        repeat (4) addInstr(CorePkg::NopInstr);
        addInstr(iType(CorePkg::OpLui, 5'd0, 5'd0, 16'h1234));
        addInstr(iType(CorePkg::OpOri, 5'd0, 5'd0, 16'h0005));
        addInstr(rType(CorePkg::FnAddu, 5'd0, 5'd0, 5'd0, 5'd0));
        repeat (4) addInstr(CorePkg::NopInstr);
    endtask

    task automatic buildMain();
        CorePkg::WordT value;
        progLen = 0;
        // ORI right behind its LUI
        for (int r = 1; r <= 6; r++) begin
            value = $random(seed);
            addInstr(iType(CorePkg::OpLui, CorePkg::RegAddrT'(r), 5'd0, value[31:16]));
            addInstr(iType(CorePkg::OpOri, CorePkg::RegAddrT'(r), CorePkg::RegAddrT'(r),
                           value[15:0]));
        end
        addInstr(rType(CorePkg::FnAddu, 5'd7, 5'd1, 5'd2, 5'd0));
        addInstr(rType(CorePkg::FnSubu, 5'd8, 5'd1, 5'd2, 5'd0));
        addInstr(rType(CorePkg::FnAnd, 5'd9, 5'd3, 5'd4, 5'd0));
        addInstr(rType(CorePkg::FnOr, 5'd10, 5'd3, 5'd4, 5'd0));
        addInstr(rType(CorePkg::FnXor, 5'd11, 5'd5, 5'd6, 5'd0));
        addInstr(rType(CorePkg::FnNor, 5'd12, 5'd5, 5'd6, 5'd0));
        // All ones doubled wraps around
        addInstr(iType(CorePkg::OpLui, 5'd13, 5'd0, 16'hFFFF));
        addInstr(iType(CorePkg::OpOri, 5'd13, 5'd13, 16'hFFFF));
        addInstr(rType(CorePkg::FnAddu, 5'd14, 5'd13, 5'd13, 5'd0));
        addInstr(rType(CorePkg::FnSlt, 5'd15, 5'd1, 5'd2, 5'd0));
        addInstr(rType(CorePkg::FnSlt, 5'd16, 5'd2, 5'd1, 5'd0));
        addInstr(rType(CorePkg::FnSlt, 5'd17, 5'd13, 5'd0, 5'd0));
        value = $random(seed);
        addInstr(rType(CorePkg::FnSll, 5'd18, 5'd0, 5'd3, value[4:0]));
        addInstr(rType(CorePkg::FnSrl, 5'd19, 5'd0, 5'd4, value[9:5]));
        addInstr(iType(CorePkg::OpAddiu, 5'd20, 5'd5, {1'b1, value[30:16]}));
        // Dependent chain, distances 1, 2 and 3
        addInstr(rType(CorePkg::FnAddu, 5'd21, 5'd1, 5'd2, 5'd0));
        addInstr(rType(CorePkg::FnXor, 5'd22, 5'd21, 5'd3, 5'd0));
        addInstr(rType(CorePkg::FnSubu, 5'd23, 5'd21, 5'd22, 5'd0));
        addInstr(rType(CorePkg::FnOr, 5'd24, 5'd21, 5'd22, 5'd0));
        addInstr(rType(CorePkg::FnNor, 5'd25, 5'd24, 5'd23, 5'd0));
        // Register 0 target, then a load opcode and an unknown function
        addInstr(rType(CorePkg::FnAddu, 5'd0, 5'd1, 5'd2, 5'd0));
        addInstr(iType(6'h23, 5'd1, 5'd2, 16'h0010));
        addInstr({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3F});
    endtask

    // Checks --------------------

    task automatic checkWord(input CorePkg::WordT actual, input CorePkg::WordT expected,
                             input CorePkg::RegAddrT regIdx);
        if (actual !== expected) begin
            $display("[FAIL] %0t: register %0d read %h, expected %h",
                     $time, regIdx, actual, expected);
            $display("Done: errors found");
            $fatal(1, "Register mismatch");
        end
    endtask

    task automatic checkAddr(input logic [AddrWidth-1:0] actual,
                             input logic [AddrWidth-1:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t: InstrAddr %h, expected %h", $time, actual, expected);
            $display("Done: errors found");
            $fatal(1, "Fetch address mismatch");
        end
    endtask

    task automatic runProgram();
        expRegs = '{default: '0};
        for (int i = 0; i < progLen; i++) begin
            modelStep(progMem[i[5:0]]);
        end
        @(negedge Clock);
        nReset = 1'b0;
        repeat (ResetCycles) @(negedge Clock);
        nReset = 1'b1;
        // PC starts at 0 and steps one word per cycle
        for (int c = 0; c < progLen + DrainCycles; c++) begin
            checkAddr(InstrAddr, AddrWidth'(4 * c));
            @(negedge Clock);
        end
        for (int i = 0; i < 32; i++) begin
            @(negedge Clock);
            RegAddr = CorePkg::RegAddrT'(i);
            @(posedge Clock);
            checkWord(RegData, expRegs[RegAddr], RegAddr);
        end
    endtask

    initial begin
        seed    = 32'h92ee35ce;
        nReset  = 1'b0;
        RegAddr = '0;
        progLen = 0;
        buildZero();
        runProgram();
        buildMain();
        runProgram();
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(TimeoutCycles * ClockPeriod);
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* verif/PipeCore_checker.sv */
//--------------------
// Assertions on the execute stage writeback
// Bound into ExecuteStage below
//--------------------

module PipeCore_checker (
    input logic             Clock,
    input logic             nReset,
    input logic             WbValid,
    input CorePkg::RegAddrT WbAddr
);

    // Decode drops register 0 writes before writeback
    noZeroWrite: assert property (@(posedge Clock) disable iff (!nReset)
        WbValid |-> WbAddr != '0)
        else $error("Write to register 0 reached writeback");

    // Reset NOP and cleared decode register keep writeback idle while refilling
    idleAfterReset: assert property (@(posedge Clock) !$past(nReset, 3) |-> !WbValid)
        else $error("Writeback valid while the pipeline refills after reset");

    knownAddr: assert property (@(posedge Clock) disable iff (!nReset)
        WbValid |-> !$isunknown(WbAddr))
        else $error("Writeback address unknown while valid");

endmodule

bind ExecuteStage PipeCore_checker u_PipeCore_checker (
    .Clock   (Clock),
    .nReset  (nReset),
    .WbValid (WbValid),
    .WbAddr  (WbAddr)
);

/* src/PipeCore.sv */
//--------------------
// Top level of the integer pipeline core
// Fetch, decode, execute and register file with plain ports for the
// instruction memory and the register check port
//--------------------

module PipeCore #(
    parameter int AddrWidth = 16
) (
    input  logic                 Clock,
    input  logic                 nReset,
    input  CorePkg::WordT        InstrMem,
    input  CorePkg::RegAddrT     RegAddr,
    output logic [AddrWidth-1:0] InstrAddr,
    output CorePkg::WordT        RegData
);

    CorePkg::WordT    instr;
    CorePkg::RegAddrT rsAddr;
    CorePkg::RegAddrT rtAddr;
    CorePkg::WordT    rsData;
    CorePkg::WordT    rtData;
    logic             exValid;
    CorePkg::RegAddrT exAddr;
    CorePkg::WordT    exResult;
    logic             wbValid;
    CorePkg::RegAddrT wbAddr;
    CorePkg::WordT    wbData;

    DecodeBus decodeBus ();

    InstrFetch #(
        .AddrWidth (AddrWidth)
    ) u_InstrFetch (
        .Clock     (Clock),
        .nReset    (nReset),
        .InstrMem  (InstrMem),
        .InstrAddr (InstrAddr),
        .Instr     (instr)
    );

    DecodeStage u_DecodeStage (
        .Clock    (Clock),
        .nReset   (nReset),
        .Instr    (instr),
        .RsData   (rsData),
        .RtData   (rtData),
        .ExValid  (exValid),
        .ExAddr   (exAddr),
        .ExResult (exResult),
        .WbValid  (wbValid),
        .WbAddr   (wbAddr),
        .WbData   (wbData),
        .RsAddr   (rsAddr),
        .RtAddr   (rtAddr),
        .Bus      (decodeBus.Source)
    );

    ExecuteStage u_ExecuteStage (
        .Clock    (Clock),
        .nReset   (nReset),
        .Bus      (decodeBus.Sink),
        .ExValid  (exValid),
        .ExAddr   (exAddr),
        .ExResult (exResult),
        .WbValid  (wbValid),
        .WbAddr   (wbAddr),
        .WbData   (wbData)
    );

    RegisterFile u_RegisterFile (
        .Clock   (Clock),
        .nReset  (nReset),
        .WbValid (wbValid),
        .WbAddr  (wbAddr),
        .WbData  (wbData),
        .RsAddr  (rsAddr),
        .RtAddr  (rtAddr),
        .RegAddr (RegAddr),
        .RsData  (rsData),
        .RtData  (rtData),
        .RegData (RegData)
    );

endmodule

/* src/RegisterFile.sv */
//--------------------
// Architectural register file
// One write port from writeback, two decode read ports with
// write-through, and a plain read port for checking
//--------------------

module RegisterFile (
    input  logic              Clock,
    input  logic              nReset,
    input  logic              WbValid,
    input  CorePkg::RegAddrT  WbAddr,
    input  CorePkg::WordT     WbData,
    input  CorePkg::RegAddrT  RsAddr,
    input  CorePkg::RegAddrT  RtAddr,
    input  CorePkg::RegAddrT  RegAddr,
    output CorePkg::WordT     RsData,
    output CorePkg::WordT     RtData,
    output CorePkg::WordT     RegData
);

    CorePkg::WordT regs [32];

    // Register 0 is never written
    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (WbValid && WbAddr != '0) begin
            regs[WbAddr] <= WbData;
        end
    end

    function automatic CorePkg::WordT readPort(input CorePkg::RegAddrT addr);
        if (addr == '0) begin
            return '0;
        end else if (WbValid && WbAddr == addr) begin
            return WbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        RsData = readPort(RsAddr);
        RtData = readPort(RtAddr);
    end

    assign RegData = regs[RegAddr];

endmodule

/* src/ExecuteStage.sv */
//--------------------
// Execute stage
// ALU and shifter for the decoded operation. The result goes back to
// decode at once for forwarding and is registered as the writeback
//--------------------

module ExecuteStage (
    input  logic              Clock,
    input  logic              nReset,
    DecodeBus.Sink            Bus,
    output logic              ExValid,
    output CorePkg::RegAddrT  ExAddr,
    output CorePkg::WordT     ExResult,
    output logic              WbValid,
    output CorePkg::RegAddrT  WbAddr,
    output CorePkg::WordT     WbData
);

    CorePkg::WordT opA;
    CorePkg::WordT opB;

    assign opA = Bus.OperandA;
    assign opB = Bus.OperandB;

    // ALU --------------

    always_comb begin
        case (Bus.AluOp)
            CorePkg::AluAdd: ExResult = opA + opB;
            CorePkg::AluSub: ExResult = opA - opB;
            CorePkg::AluAnd: ExResult = opA & opB;
            CorePkg::AluOr:  ExResult = opA | opB;
            CorePkg::AluXor: ExResult = opA ^ opB;
            CorePkg::AluNor: ExResult = ~(opA | opB);
            // Signed compare
            CorePkg::AluSlt: ExResult = {31'b0, $signed(opA) < $signed(opB)};
            // Shifts act on rt
            CorePkg::AluSll: ExResult = opB << Bus.Shamt;
            CorePkg::AluSrl: ExResult = opB >> Bus.Shamt;
            CorePkg::AluLui: ExResult = {opB[15:0], 16'h0000};
            default:         ExResult = '0;
        endcase
    end

    assign ExValid = Bus.Valid;
    assign ExAddr  = Bus.Dest;

    // Writeback register --------------

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            WbValid <= 1'b0;
            WbAddr  <= '0;
            WbData  <= '0;
        end else begin
            WbValid <= ExValid;
            WbAddr  <= ExAddr;
            WbData  <= ExResult;
        end
    end

endmodule

/* src/DecodeStage.sv */
//--------------------
// Decode stage
// Splits the instruction, selects the ALU operation and immediate,
// and forwards operands from execute and writeback before they reach
// the register file
//--------------------

module DecodeStage (
    input  logic              Clock,
    input  logic              nReset,
    input  CorePkg::WordT     Instr,
    input  CorePkg::WordT     RsData,
    input  CorePkg::WordT     RtData,
    input  logic              ExValid,
    input  CorePkg::RegAddrT  ExAddr,
    input  CorePkg::WordT     ExResult,
    input  logic              WbValid,
    input  CorePkg::RegAddrT  WbAddr,
    input  CorePkg::WordT     WbData,
    output CorePkg::RegAddrT  RsAddr,
    output CorePkg::RegAddrT  RtAddr,
    DecodeBus.Source          Bus
);

    CorePkg::RFormT   rForm;
    CorePkg::IFormT   iForm;
    CorePkg::AluOpE   aluOp;
    CorePkg::RegAddrT dest;
    CorePkg::WordT    imm;
    CorePkg::WordT    rsFwd;
    CorePkg::WordT    rtFwd;
    logic             useImm;
    logic             signExt;

    assign rForm  = Instr;
    assign iForm  = Instr;
    assign RsAddr = rForm.rs;
    assign RtAddr = rForm.rt;

    // Newest value wins
    function automatic CorePkg::WordT forwardOperand(input CorePkg::RegAddrT addr,
                                                     input CorePkg::WordT rfData);
        if (addr == '0) begin
            return '0;
        end else if (ExValid && ExAddr == addr) begin
            return ExResult;
        end else if (WbValid && WbAddr == addr) begin
            return WbData;
        end
        return rfData;
    endfunction

    always_comb begin
        aluOp   = CorePkg::AluNop;
        dest    = rForm.rd;
        useImm  = 1'b0;
        signExt = 1'b0;
        case (CorePkg::OpcodeE'(rForm.opcode))
            CorePkg::OpSpecial: begin
                case (CorePkg::FuncE'(rForm.func))
                    CorePkg::FnSll:  aluOp = CorePkg::AluSll;
                    CorePkg::FnSrl:  aluOp = CorePkg::AluSrl;
                    CorePkg::FnAddu: aluOp = CorePkg::AluAdd;
                    CorePkg::FnSubu: aluOp = CorePkg::AluSub;
                    CorePkg::FnAnd:  aluOp = CorePkg::AluAnd;
                    CorePkg::FnOr:   aluOp = CorePkg::AluOr;
                    CorePkg::FnXor:  aluOp = CorePkg::AluXor;
                    CorePkg::FnNor:  aluOp = CorePkg::AluNor;
                    CorePkg::FnSlt:  aluOp = CorePkg::AluSlt;
                    default:         aluOp = CorePkg::AluNop;
                endcase
            end
            CorePkg::OpAddiu: begin
                aluOp   = CorePkg::AluAdd;
                dest    = iForm.rt;
                useImm  = 1'b1;
                signExt = 1'b1;
            end
            CorePkg::OpOri: begin
                aluOp  = CorePkg::AluOr;
                dest   = iForm.rt;
                useImm = 1'b1;
            end
            CorePkg::OpLui: begin
                aluOp  = CorePkg::AluLui;
                dest   = iForm.rt;
                useImm = 1'b1;
            end
            default: aluOp = CorePkg::AluNop;
        endcase
    end

    assign imm = signExt ? {{16{iForm.imm[15]}}, iForm.imm} : {16'h0000, iForm.imm};

    always_comb begin
        rsFwd = forwardOperand(rForm.rs, RsData);
        rtFwd = forwardOperand(rForm.rt, RtData);
    end

    // Decode register
    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            Bus.Valid    <= 1'b0;
            Bus.AluOp    <= CorePkg::AluNop;
            Bus.OperandA <= '0;
            Bus.OperandB <= '0;
            Bus.Shamt    <= '0;
            Bus.Dest     <= '0;
        end else begin
            Bus.Valid    <= (aluOp != CorePkg::AluNop) && (dest != '0);
            Bus.AluOp    <= aluOp;
            Bus.OperandA <= rsFwd;
            Bus.OperandB <= useImm ? imm : rtFwd;
            Bus.Shamt    <= rForm.shamt;
            Bus.Dest     <= dest;
        end
    end

endmodule

/* src/InstrFetch.sv */
//--------------------
// Fetch stage
// Program counter stepping by one word per cycle, and the fetch
// register that holds the instruction for decode
//--------------------

module InstrFetch #(
    parameter int AddrWidth = 16
) (
    input  logic                 Clock,
    input  logic                 nReset,
    input  CorePkg::WordT        InstrMem,
    output logic [AddrWidth-1:0] InstrAddr,
    output CorePkg::WordT        Instr
);

    logic [AddrWidth-1:0] pc;

    assign InstrAddr = pc;

    // No stalls, so the PC moves every cycle
    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            pc <= '0;
        end else begin
            pc <= pc + AddrWidth'(4);
        end
    end

    // Fetch register
    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            Instr <= CorePkg::NopInstr;
        end else begin
            Instr <= InstrMem;
        end
    end

endmodule

/* src/DecodeBus.sv */
//--------------------
// Decoded operation passed from decode to execute
// One registered operation per cycle, no handshake
//--------------------

interface DecodeBus;

    // High when the operation writes a register
    logic               Valid;
    CorePkg::AluOpE     AluOp;
    CorePkg::WordT      OperandA;
    CorePkg::WordT      OperandB;
    logic [4:0]         Shamt;
    CorePkg::RegAddrT   Dest;

    modport Source (
        output Valid, AluOp, OperandA, OperandB, Shamt, Dest
    );

    modport Sink (
        input Valid, AluOp, OperandA, OperandB, Shamt, Dest
    );

endinterface

/* src/CorePkg.sv */
//--------------------
// Shared types for the integer pipeline core
// Word and register types, instruction field layouts, opcode and
// function encodings, and the operations the execute stage performs
//--------------------

package CorePkg;

    typedef logic [31:0] WordT;
    typedef logic [4:0]  RegAddrT;

    // R-type field layout
    typedef struct packed {
        logic [5:0] opcode;
        RegAddrT    rs;
        RegAddrT    rt;
        RegAddrT    rd;
        logic [4:0] shamt;
        logic [5:0] func;
    } RFormT;

    // I-type field layout
    typedef struct packed {
        logic [5:0]  opcode;
        RegAddrT     rs;
        RegAddrT     rt;
        logic [15:0] imm;
    } IFormT;

    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpAddiu   = 6'h09,
        OpOri     = 6'h0D,
        OpLui     = 6'h0F
    } OpcodeE;

    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnNor  = 6'h27,
        FnSlt  = 6'h2A
    } FuncE;

    typedef enum logic [3:0] {
        AluNop, AluAdd, AluSub, AluAnd, AluOr, AluXor,
        AluNor, AluSlt, AluSll, AluSrl, AluLui
    } AluOpE;

    // SLL r0,r0,0, never writes
    localparam WordT NopInstr = 32'h0000_0000;

endpackage
